// ==== design/eeprom_params.svh ====
`ifndef EEPROM_PARAMS_SVH
`define EEPROM_PARAMS_SVH

// byte address of the 2 KB part
// bits 10..8 go into the control byte as block select
`define EE_ADDR_W 11

// device type code, upper nibble of control byte
`define EE_DEV_CODE 4'b1010

// CLK cycles per quarter of an SCL period
`define I2C_QUARTER 4

`endif

// ==== design/wb_pkg.sv ====
`default_nettype none

`include "eeprom_params.svh"

package wb_pkg;

    // master to slave, classic cycle
    typedef struct packed {
        logic                  cyc;
        logic                  stb;
        logic                  we;
        logic [`EE_ADDR_W-1:0] adr;
        logic [7:0]            dat;
    } wb_req_t;

    // slave to master
    typedef struct packed {
        logic       ack;
        logic [7:0] dat;   // read data, valid with ack
    } wb_rsp_t;

endpackage

`default_nettype wire

// ==== design/i2c_pkg.sv ====
`default_nettype none

package i2c_pkg;

    typedef enum logic [1:0] {
        CMD_START,
        CMD_STOP,
        CMD_WRITE,
        CMD_READ
    } bit_cmd_t;

    typedef struct packed {
        logic     valid;
        bit_cmd_t cmd;
        logic     din;    // level sent by CMD_WRITE
    } bit_req_t;

    typedef struct packed {
        logic done;
        logic dout;       // SDA sampled mid SCL high
    } bit_rsp_t;

    // byte level sequencer
    typedef enum logic [3:0] {
        ST_IDLE,
        ST_START,
        ST_CTRL_W,
        ST_ADDR,
        ST_DATA_W,
        ST_RESTART,
        ST_CTRL_R,
        ST_DATA_R,
        ST_MACK,
        ST_STOP,
        ST_POLL_START,
        ST_POLL_CTRL,
        ST_POLL_STOP,
        ST_ACK
    } seq_state_t;

endpackage

`default_nettype wire

// ==== design/i2c_bit_engine.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "eeprom_params.svh"

module i2c_bit_engine (
    input  logic              CLK,
    input  logic              RESET,
    input  i2c_pkg::bit_req_t req,
    output i2c_pkg::bit_rsp_t rsp,
    output logic              scl,
    output logic              sda_drive_low,
    input  logic              sda_in
);
    import i2c_pkg::*;

    localparam int QUARTER = `I2C_QUARTER;
    localparam int QW      = (QUARTER > 1) ? $clog2(QUARTER) : 1;

    logic          busy;
    logic [QW-1:0] qcnt;
    logic [1:0]    phase;
    bit_cmd_t      cmd_q;
    logic          din_q;
    logic          dout_q;
    logic          accept;
    logic          quarter_end;

    // returns {scl, sda_drive_low} for one quarter of a command
    function automatic logic [1:0] phase_out(bit_cmd_t cmd, logic din, logic [1:0] ph);
        logic s;
        logic low;
        begin
            s   = (ph == 2'd1) || (ph == 2'd2);
            low = 1'b0;
            case (cmd)
                CMD_START:
                begin
                    low = ph[1];              // SDA falls in the second high quarter
                end
                CMD_STOP:
                begin
                    s   = (ph != 2'd0);       // ends with SCL high
                    low = !ph[1];
                end
                CMD_WRITE:
                begin
                    low = !din;
                end
                default:
                begin
                    low = 1'b0;               // read, line released
                end
            endcase
            phase_out = {s, low};
        end
    endfunction

    assign accept      = req.valid && !busy;
    assign quarter_end = busy && (qcnt == QW'(QUARTER - 1));

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            busy          <= 1'b0;
            qcnt          <= '0;
            phase         <= 2'd0;
            scl           <= 1'b1;
            sda_drive_low <= 1'b0;
        end
        else if (accept)
        begin
            busy                 <= 1'b1;
            qcnt                 <= '0;
            phase                <= 2'd0;
            {scl, sda_drive_low} <= phase_out(req.cmd, req.din, 2'd0);
        end
        else if (busy)
        begin
            if (quarter_end)
            begin
                qcnt  <= '0;
                phase <= phase + 2'd1;
                if (phase == 2'd3)
                begin
                    busy <= 1'b0;             // outputs hold until next command
                end
                else
                begin
                    {scl, sda_drive_low} <= phase_out(cmd_q, din_q, phase + 2'd1);
                end
            end
            else
            begin
                qcnt <= qcnt + 1'b1;
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (accept)
        begin
            cmd_q <= req.cmd;
            din_q <= req.din;
        end
        if (quarter_end && phase == 2'd1)
        begin
            dout_q <= sda_in;                 // middle of SCL high
        end
    end

    always_comb
    begin
        rsp.done = quarter_end && (phase == 2'd3);
        rsp.dout = dout_q;
    end

    a_no_overlap: assert property (
        @(posedge CLK) disable iff (RESET)
        req.valid |-> !busy
    ) else $error("bit command issued while engine busy");

    // SCL only moves on a quarter boundary
    a_scl_quarter: assert property (
        @(posedge CLK) disable iff (RESET)
        $changed(scl) |-> (busy && qcnt == '0)
    ) else $error("SCL changed inside a quarter period");

endmodule

`default_nettype wire

// ==== design/eeprom_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "eeprom_params.svh"

module eeprom_sequencer (
    input  logic              CLK,
    input  logic              RESET,
    input  wb_pkg::wb_req_t   wb_req,
    output wb_pkg::wb_rsp_t   wb_rsp,
    output i2c_pkg::bit_req_t bit_req,
    input  i2c_pkg::bit_rsp_t bit_rsp
);
    import i2c_pkg::*;

    seq_state_t            state;
    seq_state_t            state_d;
    logic                  pending;      // bit command in flight
    logic                  retry;
    logic                  poll_ok;
    logic [3:0]            bitcnt;
    logic [`EE_ADDR_W-1:0] adr_q;
    logic                  we_q;
    logic [7:0]            wdat_q;
    logic [7:0]            shreg;
    logic [7:0]            rdat_q;
    bit_cmd_t              next_cmd;
    logic                  next_din;
    logic                  issue;
    logic                  byte_done;
    logic                  nack;
    logic                  wb_start;

    function automatic logic [7:0] ctrl_byte(logic rd);
        ctrl_byte = {`EE_DEV_CODE, adr_q[`EE_ADDR_W-1:8], rd};
    endfunction

    assign wb_start  = wb_req.cyc && wb_req.stb;
    assign byte_done = bit_rsp.done && bitcnt[3];   // ninth bit is the slave ack
    assign nack      = bit_rsp.dout;
    assign issue     = !pending && (state != ST_IDLE) && (state != ST_ACK);

    // command for the current state
    always_comb
    begin
        next_cmd = CMD_WRITE;
        next_din = 1'b1;
        case (state)
            ST_START, ST_RESTART, ST_POLL_START: next_cmd = CMD_START;
            ST_STOP, ST_POLL_STOP:               next_cmd = CMD_STOP;
            ST_DATA_R:                           next_cmd = CMD_READ;
            ST_MACK:                             next_din = 1'b1;    // no-ack ends the read
            default:
            begin
                if (bitcnt[3])
                begin
                    next_cmd = CMD_READ;
                end
                else
                begin
                    next_din = shreg[7];
                end
            end
        endcase
    end

    always_comb
    begin
        state_d = state;
        case (state)
            ST_IDLE:       if (wb_start) state_d = ST_START;
            ST_START:      if (bit_rsp.done) state_d = ST_CTRL_W;
            ST_CTRL_W:     if (byte_done) state_d = nack ? ST_STOP : ST_ADDR;
            ST_ADDR:
            begin
                if (byte_done)
                begin
                    state_d = nack ? ST_STOP : (we_q ? ST_DATA_W : ST_RESTART);
                end
            end
            ST_DATA_W:     if (byte_done) state_d = ST_STOP;
            ST_RESTART:    if (bit_rsp.done) state_d = ST_CTRL_R;
            ST_CTRL_R:     if (byte_done) state_d = nack ? ST_STOP : ST_DATA_R;
            ST_DATA_R:     if (bit_rsp.done && bitcnt == 4'd7) state_d = ST_MACK;
            ST_MACK:       if (bit_rsp.done) state_d = ST_STOP;
            ST_STOP:
            begin
                if (bit_rsp.done)
                begin
                    state_d = retry ? ST_START : (we_q ? ST_POLL_START : ST_ACK);
                end
            end
            ST_POLL_START: if (bit_rsp.done) state_d = ST_POLL_CTRL;
            ST_POLL_CTRL:  if (byte_done) state_d = ST_POLL_STOP;
            ST_POLL_STOP:  if (bit_rsp.done) state_d = poll_ok ? ST_ACK : ST_POLL_START;
            ST_ACK:        state_d = ST_IDLE;
            default:       state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state   <= ST_IDLE;
            pending <= 1'b0;
            retry   <= 1'b0;
            poll_ok <= 1'b0;
            bitcnt  <= 4'd0;
            bit_req <= '0;
        end
        else
        begin
            state         <= state_d;
            bit_req.valid <= 1'b0;
            if (issue)
            begin
                bit_req.valid <= 1'b1;
                bit_req.cmd   <= next_cmd;
                bit_req.din   <= next_din;
                pending       <= 1'b1;
            end
            else if (bit_rsp.done)
            begin
                pending <= 1'b0;
            end

            if (state_d != state)
                bitcnt <= 4'd0;
            else if (bit_rsp.done)
                bitcnt <= bitcnt + 4'd1;

            // slave nack in a transfer byte, stop and start over
            if (byte_done && nack &&
                (state inside {ST_CTRL_W, ST_ADDR, ST_DATA_W, ST_CTRL_R}))
                retry <= 1'b1;
            else if (state == ST_STOP && bit_rsp.done)
                retry <= 1'b0;

            if (state == ST_POLL_CTRL && byte_done)
                poll_ok <= !nack;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (state == ST_IDLE && wb_start)
        begin
            adr_q  <= wb_req.adr;
            we_q   <= wb_req.we;
            wdat_q <= wb_req.dat;
        end

        if (bit_rsp.done)
            shreg <= {shreg[6:0], (state == ST_DATA_R) ? bit_rsp.dout : 1'b0};   // MSB first

        if (state_d != state)
        begin
            case (state_d)
                ST_CTRL_W, ST_POLL_CTRL: shreg <= ctrl_byte(1'b0);
                ST_ADDR:                 shreg <= adr_q[7:0];
                ST_DATA_W:               shreg <= wdat_q;
                ST_CTRL_R:               shreg <= ctrl_byte(1'b1);
                default:                 ;
            endcase
        end

        if (state == ST_DATA_R && bit_rsp.done && bitcnt == 4'd7)
            rdat_q <= {shreg[6:0], bit_rsp.dout};
    end

    always_comb
    begin
        wb_rsp.ack = (state == ST_ACK);
        wb_rsp.dat = rdat_q;
    end

    a_ack_pulse: assert property (
        @(posedge CLK) disable iff (RESET)
        wb_rsp.ack |=> !wb_rsp.ack
    ) else $error("ack longer than one cycle");

    a_state_legal: assert property (
        @(posedge CLK) disable iff (RESET)
        state inside {[ST_IDLE:ST_ACK]}
    ) else $error("sequencer state out of range");

endmodule

`default_nettype wire

// ==== design/eeprom_wr.sv ====
`timescale 1ns/1ps
`default_nettype none

module eeprom_wr (
    input  logic            CLK,
    input  logic            RESET,
    input  wb_pkg::wb_req_t wb_req,
    output wb_pkg::wb_rsp_t wb_rsp,
    output logic            SCL,
    inout  wire             SDA
);
    import i2c_pkg::*;

    bit_req_t bit_req;
    bit_rsp_t bit_rsp;
    logic     sda_drive_low;
    logic     sda_in;

    eeprom_sequencer u_seq (
        .CLK     (CLK),
        .RESET   (RESET),
        .wb_req  (wb_req),
        .wb_rsp  (wb_rsp),
        .bit_req (bit_req),
        .bit_rsp (bit_rsp)
    );

    i2c_bit_engine u_bit (
        .CLK           (CLK),
        .RESET         (RESET),
        .req           (bit_req),
        .rsp           (bit_rsp),
        .scl           (SCL),
        .sda_drive_low (sda_drive_low),
        .sda_in        (sda_in)
    );

    // open drain, high level comes from the pull-up
    assign SDA    = sda_drive_low ? 1'b0 : 1'bz;
    assign sda_in = SDA;

endmodule

`default_nettype wire

// ==== sim/eeprom_model.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "eeprom_params.svh"

module eeprom_model #(
    parameter int SEED = 23684
) (
    input  wire  scl,
    inout  wire  sda,
    output logic protocol_error,
    output int   busy_nacks      // nacked polls since the last write
);
    logic [7:0]            mem [0:(1 << `EE_ADDR_W) - 1];
    logic [`EE_ADDR_W-1:0] ptr;
    logic [7:0]            shreg;
    logic [7:0]            tx;
    logic [7:0]            wdata;
    logic                  drive_low;
    logic                  active;
    logic                  sending;
    logic                  send_armed;
    logic                  ack_out;
    logic                  write_pending;
    logic                  scl_prev;
    logic                  sda_prev;
    int                    bitcnt;
    int                    byte_idx;
    int                    busy_left;
    integer                seed;

    assign sda = drive_low ? 1'b0 : 1'bz;

    initial
    begin
        seed           = SEED;
        protocol_error = 1'b0;
        busy_nacks     = 0;
        busy_left      = 0;
        drive_low      = 1'b0;
        active         = 1'b0;
        sending        = 1'b0;
        send_armed     = 1'b0;
        write_pending  = 1'b0;
        bitcnt         = 0;
        for (int a = 0; a < (1 << `EE_ADDR_W); a++)
            mem[a] = a[7:0] ^ {a[10:8], 5'd0};
    end

    // one byte received, decide the ack bit
    task automatic take_byte();
        ack_out = 1'b1;
        if (byte_idx == 0)
        begin
            if (shreg[7:4] != `EE_DEV_CODE)
            begin
                protocol_error = 1'b1;
                ack_out        = 1'b0;
            end
            else if (busy_left > 0)
            begin
                busy_left  = busy_left - 1;    // internal write cycle still running
                busy_nacks = busy_nacks + 1;
                ack_out    = 1'b0;
            end
            else
            begin
                ptr[`EE_ADDR_W-1:8] = shreg[3:1];
                send_armed          = shreg[0];
            end
        end
        else if (byte_idx == 1)
            ptr[7:0] = shreg;
        else
        begin
            wdata         = shreg;
            write_pending = 1'b1;
        end
        byte_idx = byte_idx + 1;
    endtask

    always @(scl or sda)
    begin
        if (scl === 1'b1 && scl_prev === 1'b0)
        begin
            if (active && bitcnt < 8)
            begin
                shreg  = {shreg[6:0], sda};
                bitcnt = bitcnt + 1;
                if (bitcnt == 8 && !sending)
                    take_byte();
            end
            else if (active)
            begin
                if (sending && sda !== 1'b0)
                begin
                    sending = 1'b0;            // master nack ends the read
                    active  = 1'b0;
                end
                if (send_armed)
                begin
                    sending = 1'b1;
                    tx      = mem[ptr];
                end
                send_armed = 1'b0;
                bitcnt     = 0;
            end
        end
        else if (scl === 1'b0 && scl_prev === 1'b1)
        begin
            if (active && bitcnt == 8)
                drive_low = sending ? 1'b0 : ack_out;
            else if (active && sending)
                drive_low = !tx[7 - bitcnt];
            else
                drive_low = 1'b0;
        end
        // the SCL rise ahead of a start or stop has already counted as bit 1
        else if (scl === 1'b1 && scl_prev === 1'b1 && sda_prev === 1'b1 && sda === 1'b0)
        begin
            if (active && bitcnt != 1)
                protocol_error = 1'b1;         // start inside a byte
            active     = 1'b1;
            sending    = 1'b0;
            send_armed = 1'b0;
            bitcnt     = 0;
            byte_idx   = 0;
        end
        else if (scl === 1'b1 && scl_prev === 1'b1 && sda_prev === 1'b0 && sda === 1'b1)
        begin
            if (active && bitcnt != 1)
                protocol_error = 1'b1;         // stop inside a byte
            if (write_pending)
            begin
                mem[ptr]      = wdata;
                write_pending = 1'b0;
                busy_left     = 1 + ($unsigned($random(seed)) % 4);
                busy_nacks    = 0;
            end
            active     = 1'b0;
            sending    = 1'b0;
            send_armed = 1'b0;
        end
        scl_prev = scl;
        sda_prev = sda;
    end

endmodule

`default_nettype wire

// ==== sim/tb_eeprom_wr.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "eeprom_params.svh"

module tb_eeprom_wr;
    import wb_pkg::*;

    localparam int     N_RANDOM = 200;
    localparam int     N_BUSY   = 20;
    localparam int     CMD_CYC  = 4 * `I2C_QUARTER;
    localparam int     WR_CYC   = (29 + 5 * 11) * CMD_CYC;   // start, 27 bits, stop, 5 polls
    localparam int     N_TX     = N_RANDOM + 1 + 2 * N_BUSY;
    // factor 2 covers the idle cycles between bit commands
    localparam longint LIMIT_NS = 64'd20 * (N_TX * WR_CYC * 2 + 1000);

    logic                  CLK;
    logic                  RESET;
    wb_req_t               wb_req;
    wb_rsp_t               wb_rsp;
    wire                   scl;
    wire                   sda;
    logic                  protocol_error;
    int                    busy_nacks;
    integer                seed;
    logic [7:0]            ref_mem [0:(1 << `EE_ADDR_W) - 1];
    int                    ack_count;
    int                    tx_count;
    logic [7:0]            blocks_seen;

    pullup (sda);

    eeprom_wr UUT (
        .CLK    (CLK),
        .RESET  (RESET),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp),
        .SCL    (scl),
        .SDA    (sda)
    );

    eeprom_model u_eeprom (
        .scl            (scl),
        .sda            (sda),
        .protocol_error (protocol_error),
        .busy_nacks     (busy_nacks)
    );

    always #10 CLK = ~CLK;

    task automatic abort_run();
        $display("Done: errors found");
        $fatal(1, "simulation stopped on failure");
    endtask

    task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
        if (expected !== actual)
        begin
            $display("[ERROR] %0t %s expected %0h got %0h", $time, name, expected, actual);
            abort_run();
        end
    endtask

    // one classic cycle, waits for ack
    task automatic wb_access(input logic we, input logic [`EE_ADDR_W-1:0] adr,
                             input logic [7:0] dat, output logic [7:0] rdat);
        int waited;
        waited = 0;
        @(posedge CLK);
        wb_req <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat};
        @(negedge CLK);
        while (wb_rsp.ack !== 1'b1)
        begin
            waited++;
            if (waited > 2 * WR_CYC)
            begin
                $display("no ack within %0d cycles for address %0h", waited, adr);
                abort_run();
            end
            @(negedge CLK);
        end
        rdat = wb_rsp.dat;
        @(posedge CLK);
        wb_req <= '0;
        tx_count++;
        check_value("ack_count", tx_count, ack_count);
        if (protocol_error)
        begin
            $display("EEPROM monitor saw a bus protocol error near %0t", $time);
            abort_run();
        end
        blocks_seen[adr[10:8]] = 1'b1;
    endtask

    task automatic write_byte(logic [`EE_ADDR_W-1:0] adr, logic [7:0] dat);
        logic [7:0] unused;
        wb_access(1'b1, adr, dat, unused);
        ref_mem[adr] = dat;
    endtask

    task automatic read_check(logic [`EE_ADDR_W-1:0] adr);
        logic [7:0] got;
        wb_access(1'b0, adr, 8'h00, got);
        check_value($sformatf("wb_rsp.dat @%0h", adr), ref_mem[adr], got);
    endtask

    // ack must pulse only inside a cycle
    always @(negedge CLK)
    begin
        if (wb_rsp.ack === 1'b1)
        begin
            ack_count++;
            if (!(wb_req.cyc && wb_req.stb))
            begin
                $display("ack seen at %0t while cyc or stb was low", $time);
                abort_run();
            end
        end
    end

    initial
    begin
        #(LIMIT_NS);
        $display("run timed out after %0d ns", LIMIT_NS);
        abort_run();
    end

    initial
    begin
        logic [`EE_ADDR_W-1:0] adr;
        logic [`EE_ADDR_W-1:0] last_wr;
        logic [7:0]            dat;
        int                    max_nacks;
        int                    tries;
        CLK         = 1'b0;
        RESET       = 1'b1;
        wb_req      = '0;
        seed        = 23684;
        ack_count   = 0;
        tx_count    = 0;
        blocks_seen = '0;
        for (int a = 0; a < (1 << `EE_ADDR_W); a++)
            ref_mem[a] = a[7:0] ^ (8'(a[10:8]) << 5);

        repeat (10) @(posedge CLK);
        RESET <= 1'b0;
        repeat (4)
        begin
            @(negedge CLK);
            check_value("SCL", 1, scl);
            check_value("SDA", 1, sda);
            check_value("wb_rsp.ack", 0, wb_rsp.ack);
        end

        read_check(11'h6c5);                   // never written, initial fill

        max_nacks = 0;
        tries     = 0;
        last_wr   = '0;
        while (max_nacks < 2 && tries < N_BUSY)
        begin
            adr = $random(seed);
            dat = $random(seed);
            write_byte(adr, dat);
            if (busy_nacks > max_nacks)
                max_nacks = busy_nacks;
            read_check(adr);
            last_wr = adr;
            tries++;
        end
        if (max_nacks < 2)
        begin
            $display("no write met a busy period with several poll rounds");
            abort_run();
        end

        for (int i = 0; i < N_RANDOM; i++)
        begin
            adr = $random(seed);
            dat = $random(seed);
            case ($unsigned($random(seed)) % 3)
                0:
                begin
                    write_byte(adr, dat);
                    last_wr = adr;
                end
                1:       read_check(adr);
                default: read_check(last_wr);
            endcase
        end
        check_value("blocks_seen", 8'hff, blocks_seen);

        $display("Done: no errors");
        $finish;
    end

endmodule

`default_nettype wire

// ==== eeprom_wr.f ====
+incdir+design
design/wb_pkg.sv
design/i2c_pkg.sv
design/i2c_bit_engine.sv
design/eeprom_sequencer.sv
design/eeprom_wr.sv
sim/eeprom_model.sv
sim/tb_eeprom_wr.sv

// ==== Bender.yml ====
package:
  name: eeprom_wr

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/wb_pkg.sv
      - design/i2c_pkg.sv
      - design/i2c_bit_engine.sv
      - design/eeprom_sequencer.sv
      - design/eeprom_wr.sv
  - target: simulation
    include_dirs:
      - design
    files:
      - sim/eeprom_model.sv
      - sim/tb_eeprom_wr.sv
